// File: src/id_pkg.sv
// RV32I base integer subset only; no compressed, CSR, SYS or M extension encodings
package id_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and encodings
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned XLEN = 32;

  typedef logic [4:0] rf_addr_t;

  // Major opcodes kept by the decoder
  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_OPIMM  = 7'h13;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_AUIPC  = 7'h17;
  localparam logic [6:0] OPC_JAL    = 7'h6f;
  localparam logic [6:0] OPC_JALR   = 7'h67;
  localparam logic [6:0] OPC_BRANCH = 7'h63;
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_STORE  = 7'h23;

  // funct7 values, ALT selects SUB and SRA
  localparam logic [6:0] FUNCT7_BASE = 7'b000_0000;
  localparam logic [6:0] FUNCT7_ALT  = 7'b010_0000;

  // Link value offset, no compressed instructions
  localparam logic [XLEN-1:0] PC_INCR = 32'd4;

  //////////////////////////////////////////////////////////////////////
  // Instruction word views
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    rf_addr_t   rs2;
    rf_addr_t   rs1;
    logic [2:0] funct3;
    rf_addr_t   rd;
    logic [6:0] opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0] imm;
    rf_addr_t    rs1;
    logic [2:0]  funct3;
    rf_addr_t    rd;
    logic [6:0]  opcode;
  } instr_i_t;

  // Store immediate split around rs2/rs1/funct3
  typedef struct packed {
    logic [6:0] imm_hi;
    rf_addr_t   rs2;
    rf_addr_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } instr_s_t;

  typedef struct packed {
    logic [19:0] imm;
    rf_addr_t    rd;
    logic [6:0]  opcode;
  } instr_u_t;

  // Same 32 bits, read in whichever format the opcode calls for
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
    instr_s_t s;
    instr_u_t u;
  } instr_word_u;

  //////////////////////////////////////////////////////////////////////
  // Enums and stage structs
  //////////////////////////////////////////////////////////////////////

  // Arithmetic ops first, branch compares in the upper half
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {SEL_REGFILE, SEL_FW_EX, SEL_FW_WB} fw_sel_e;
  typedef enum logic [1:0] {OP_A_REG, OP_A_PC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic {OP_B_REG, OP_B_IMM} op_b_sel_e;
  typedef enum logic [2:0] {IMMB_I, IMMB_S, IMMB_U, IMMB_PCINCR} imm_b_sel_e;
  typedef enum logic {OP_C_REG, OP_C_BCH} op_c_sel_e;

  typedef struct packed {
    logic [XLEN-1:0] i;
    logic [XLEN-1:0] s;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] u;
    logic [XLEN-1:0] j;
  } imm_set_t;

  typedef struct packed {
    logic            instr_valid;
    logic [XLEN-1:0] pc;
    instr_word_u     instr;
  } if_id_t;

  typedef struct packed {
    logic kill_id;
    logic halt_id;
  } ctrl_t;

  typedef struct packed {
    fw_sel_e fw_a_sel;
    fw_sel_e fw_b_sel;
  } byp_t;

  typedef struct packed {
    logic       alu_en;
    logic       alu_bch;
    logic       alu_jmp;
    logic       alu_jmpr;
    alu_op_e    alu_op;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    op_c_sel_e  op_c_sel;
    imm_b_sel_e imm_b_sel;
    logic       lsu_en;
    logic       lsu_we;
    logic [1:0] lsu_size;
    logic       lsu_sext;
    logic       rf_we;
    rf_addr_t   rf_waddr;
    logic       illegal;
  } dec_ctrl_t;

  typedef struct packed {
    logic            instr_valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_next;
    logic            alu_en;
    logic            alu_bch;
    logic            alu_jmp;
    alu_op_e         alu_op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] operand_c;
    logic            lsu_en;
    logic            lsu_we;
    logic [1:0]      lsu_size;
    logic            lsu_sext;
    logic            rf_we;
    rf_addr_t        rf_waddr;
    logic            illegal_insn;
  } id_ex_t;

endpackage

// File: src/imm_gen.sv
// Pure combinational; all immediates are built every cycle whatever the opcode
module imm_gen import id_pkg::*; (
  input  instr_word_u instr_i,
  output imm_set_t    imm_o
);

  logic sign;

  // Every RV32I immediate takes its sign from bit 31
  assign sign = instr_i.r.funct7[6];

  // I type, loads, JALR and OP-IMM
  assign imm_o.i = {{20{sign}}, instr_i.i.imm};

  // S type, store offset rebuilt from both halves
  assign imm_o.s = {{20{sign}}, instr_i.s.imm_hi, instr_i.s.imm_lo};

  // B type, bit 11 sits in instr[7], LSB always zero
  assign imm_o.b = {{19{sign}}, sign, instr_i.s.imm_lo[0],
                    instr_i.s.imm_hi[5:0], instr_i.s.imm_lo[4:1], 1'b0};

  // U type, upper 20 bits
  assign imm_o.u = {instr_i.u.imm, 12'b0};

  // J type
  // imm[19:12] from instr[19:12], imm[11] from instr[20], imm[10:1] from instr[30:21]
  assign imm_o.j = {{12{sign}}, instr_i.u.imm[7:0], instr_i.u.imm[8],
                    instr_i.u.imm[18:9], 1'b0};

endmodule

// File: src/instr_decoder.sv
// Decodes RV32I OP, OP-IMM, LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE; anything else is illegal
module instr_decoder import id_pkg::*; (
  input  instr_word_u instr_i,
  output dec_ctrl_t   dec_o
);

  // Register-register and register-immediate ALU ops share the funct3 map
  function automatic alu_op_e f3_to_alu_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  f3_to_alu_op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  f3_to_alu_op = ALU_SLL;
      3'b010:  f3_to_alu_op = ALU_SLT;
      3'b011:  f3_to_alu_op = ALU_SLTU;
      3'b100:  f3_to_alu_op = ALU_XOR;
      3'b101:  f3_to_alu_op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  f3_to_alu_op = ALU_OR;
      default: f3_to_alu_op = ALU_AND;
    endcase
  endfunction

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f7_alt;

  assign opcode = instr_i.r.opcode;
  assign funct3 = instr_i.r.funct3;
  assign funct7 = instr_i.r.funct7;
  assign f7_alt = (funct7 == FUNCT7_ALT);

  //////////////////////////////////////////////////////////////////////
  // Main decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Defaults describe a plain register-register ALU op with nothing enabled
    dec_o           = '0;
    dec_o.alu_op    = ALU_ADD;
    dec_o.op_a_sel  = OP_A_REG;
    dec_o.op_b_sel  = OP_B_REG;
    dec_o.op_c_sel  = OP_C_REG;
    dec_o.imm_b_sel = IMMB_I;
    dec_o.rf_waddr  = instr_i.r.rd;

    case (opcode)
      OPC_OP: begin
        dec_o.alu_en = 1'b1;
        dec_o.rf_we  = 1'b1;
        dec_o.alu_op = f3_to_alu_op(funct3, f7_alt);
        // Only ADD/SUB and SRL/SRA have an alternate funct7
        if (funct7 != FUNCT7_BASE && !(f7_alt && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          dec_o.illegal = 1'b1;
        end
      end

      OPC_OPIMM: begin
        dec_o.alu_en   = 1'b1;
        dec_o.rf_we    = 1'b1;
        dec_o.op_b_sel = OP_B_IMM;
        // No SUBI, so the alternate bit only counts for right shifts
        dec_o.alu_op   = f3_to_alu_op(funct3, f7_alt && (funct3 == 3'b101));
        // Shift amount is 5 bits, upper funct7 bits must be clean
        if (funct3 == 3'b001 && funct7 != FUNCT7_BASE) begin
          dec_o.illegal = 1'b1;
        end
        if (funct3 == 3'b101 && funct7 != FUNCT7_BASE && !f7_alt) begin
          dec_o.illegal = 1'b1;
        end
      end

      // LUI adds the U immediate to zero, AUIPC to pc
      OPC_LUI, OPC_AUIPC: begin
        dec_o.alu_en    = 1'b1;
        dec_o.rf_we     = 1'b1;
        dec_o.op_a_sel  = (opcode == OPC_LUI) ? OP_A_ZERO : OP_A_PC;
        dec_o.op_b_sel  = OP_B_IMM;
        dec_o.imm_b_sel = IMMB_U;
      end

      // Link value is pc + 4, the target itself comes from pc_target
      OPC_JAL, OPC_JALR: begin
        dec_o.alu_en    = 1'b1;
        dec_o.alu_jmp   = 1'b1;
        dec_o.alu_jmpr  = (opcode == OPC_JALR);
        dec_o.rf_we     = 1'b1;
        dec_o.op_a_sel  = OP_A_PC;
        dec_o.op_b_sel  = OP_B_IMM;
        dec_o.imm_b_sel = IMMB_PCINCR;
        if (opcode == OPC_JALR && funct3 != 3'b000) begin
          dec_o.illegal = 1'b1;
        end
      end

      OPC_BRANCH: begin
        dec_o.alu_en   = 1'b1;
        dec_o.alu_bch  = 1'b1;
        // Branch target travels on operand C
        dec_o.op_c_sel = OP_C_BCH;
        case (funct3)
          3'b000:  dec_o.alu_op = ALU_EQ;
          3'b001:  dec_o.alu_op = ALU_NE;
          3'b100:  dec_o.alu_op = ALU_LT;
          3'b101:  dec_o.alu_op = ALU_GE;
          3'b110:  dec_o.alu_op = ALU_LTU;
          3'b111:  dec_o.alu_op = ALU_GEU;
          default: dec_o.illegal = 1'b1;
        endcase
      end

      OPC_LOAD: begin
        dec_o.lsu_en   = 1'b1;
        dec_o.rf_we    = 1'b1;
        dec_o.op_b_sel = OP_B_IMM;
        dec_o.lsu_size = funct3[1:0];
        // LBU and LHU have funct3[2] set
        dec_o.lsu_sext = !funct3[2];
        if (funct3[1:0] == 2'b11 || funct3 == 3'b110) begin
          dec_o.illegal = 1'b1;
        end
      end

      // Store data is rs2 on operand C
      OPC_STORE: begin
        dec_o.lsu_en    = 1'b1;
        dec_o.lsu_we    = 1'b1;
        dec_o.op_b_sel  = OP_B_IMM;
        dec_o.imm_b_sel = IMMB_S;
        dec_o.lsu_size  = funct3[1:0];
        if (funct3[2] || funct3[1:0] == 2'b11) begin
          dec_o.illegal = 1'b1;
        end
      end

      default: dec_o.illegal = 1'b1;
    endcase

    // An illegal instruction must not reach any unit
    if (dec_o.illegal) begin
      dec_o.alu_en   = 1'b0;
      dec_o.alu_bch  = 1'b0;
      dec_o.alu_jmp  = 1'b0;
      dec_o.alu_jmpr = 1'b0;
      dec_o.lsu_en   = 1'b0;
      dec_o.lsu_we   = 1'b0;
      dec_o.rf_we    = 1'b0;
    end

    // x0 is hardwired zero
    if (instr_i.r.rd == '0) begin
      dec_o.rf_we = 1'b0;
    end
  end

endmodule

// File: src/operand_mux.sv
// Forwarding selects come from the controller; no hazard detection is done here
module operand_mux import id_pkg::*; (
  input  dec_ctrl_t             dec_i,
  input  imm_set_t              imm_i,
  input  logic [XLEN-1:0]       pc_i,
  input  byp_t                  byp_i,
  input  logic [1:0][XLEN-1:0]  rf_rdata_i,
  input  logic [XLEN-1:0]       rf_wdata_ex_i,
  input  logic [XLEN-1:0]       rf_wdata_wb_i,
  input  logic [XLEN-1:0]       bch_target_i,
  output logic [XLEN-1:0]       rs1_fw_o,
  output logic [XLEN-1:0]       operand_a_o,
  output logic [XLEN-1:0]       operand_b_o,
  output logic [XLEN-1:0]       operand_c_o
);

  // One forwarding mux, used for both source registers
  function automatic logic [XLEN-1:0] fw_pick(input fw_sel_e sel,
                                              input logic [XLEN-1:0] rf,
                                              input logic [XLEN-1:0] ex,
                                              input logic [XLEN-1:0] wb);
    case (sel)
      SEL_FW_EX: fw_pick = ex;
      SEL_FW_WB: fw_pick = wb;
      default:   fw_pick = rf;
    endcase
  endfunction

  logic [XLEN-1:0] rs2_fw;
  logic [XLEN-1:0] imm_b;

  // Controller picks the source, register file when no bypass is selected
  assign rs1_fw_o = fw_pick(byp_i.fw_a_sel, rf_rdata_i[0], rf_wdata_ex_i, rf_wdata_wb_i);
  assign rs2_fw   = fw_pick(byp_i.fw_b_sel, rf_rdata_i[1], rf_wdata_ex_i, rf_wdata_wb_i);

  // Operand A
  always_comb begin
    case (dec_i.op_a_sel)
      OP_A_PC:   operand_a_o = pc_i;
      OP_A_ZERO: operand_a_o = '0;
      default:   operand_a_o = rs1_fw_o;
    endcase
  end

  // Immediate for operand B
  always_comb begin
    case (dec_i.imm_b_sel)
      IMMB_S:      imm_b = imm_i.s;
      IMMB_U:      imm_b = imm_i.u;
      IMMB_PCINCR: imm_b = PC_INCR;
      default:     imm_b = imm_i.i;
    endcase
  end

  assign operand_b_o = (dec_i.op_b_sel == OP_B_IMM) ? imm_b : rs2_fw;

  // Store data, or the branch target for EX to redirect to
  assign operand_c_o = (dec_i.op_c_sel == OP_C_BCH) ? bch_target_i : rs2_fw;

endmodule

// File: src/pc_target.sv
// Targets are computed every cycle; only a jump or branch gives them meaning
module pc_target import id_pkg::*; (
  input  dec_ctrl_t       dec_i,
  input  imm_set_t        imm_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] rs1_fw_i,
  output logic [XLEN-1:0] bch_target_o,
  output logic [XLEN-1:0] jmp_target_o,
  output logic [XLEN-1:0] pc_next_o
);

  logic [XLEN-1:0] jalr_sum;

  // Branch target resolved here, taken/not taken decided in EX
  assign bch_target_o = pc_i + imm_i.b;

  // JALR base is the forwarded rs1
  assign jalr_sum = rs1_fw_i + imm_i.i;

  // JALR clears bit 0 of the sum
  assign jmp_target_o = dec_i.alu_jmpr ? {jalr_sum[XLEN-1:1], 1'b0}
                                       : pc_i + imm_i.j;

  // Fall-through address
  assign pc_next_o = pc_i + PC_INCR;

endmodule

// File: src/id_ex_pipe.sv
// Single-entry ID/EX register; payload fields hold stale data unless their enable is set
module id_ex_pipe import id_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  if_id_t          if_id_i,
  input  ctrl_t           ctrl_i,
  input  logic            ex_ready_i,
  input  dec_ctrl_t       dec_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  input  logic [XLEN-1:0] operand_c_i,
  input  logic [XLEN-1:0] pc_next_i,
  output logic            id_valid_o,
  output logic            id_ready_o,
  output id_ex_t          id_ex_o
);

  logic xfer;

  // Control state
  logic valid_q;
  logic alu_en_q;
  logic lsu_en_q;
  logic rf_we_q;
  logic illegal_q;

  // Payload
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_next_q;
  logic [XLEN-1:0] op_a_q;
  logic [XLEN-1:0] op_b_q;
  logic [XLEN-1:0] op_c_q;
  logic            alu_bch_q;
  logic            alu_jmp_q;
  alu_op_e         alu_op_q;
  logic            lsu_we_q;
  logic [1:0]      lsu_size_q;
  logic            lsu_sext_q;
  rf_addr_t        rf_waddr_q;

  //////////////////////////////////////////////////////////////////////
  // Stage handshake
  //////////////////////////////////////////////////////////////////////

  // Kill and halt both turn the instruction into a bubble
  assign id_valid_o = if_id_i.instr_valid && !ctrl_i.kill_id && !ctrl_i.halt_id;
  // A killed instruction is dropped, so IF may move on regardless of EX
  assign id_ready_o = ctrl_i.kill_id || (ex_ready_i && !ctrl_i.halt_id);
  assign xfer       = id_valid_o && ex_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q   <= 1'b0;
      alu_en_q  <= 1'b0;
      lsu_en_q  <= 1'b0;
      rf_we_q   <= 1'b0;
      illegal_q <= 1'b0;
    end else if (xfer) begin
      valid_q   <= 1'b1;
      alu_en_q  <= dec_i.alu_en;
      lsu_en_q  <= dec_i.lsu_en;
      rf_we_q   <= dec_i.rf_we;
      illegal_q <= dec_i.illegal;
    end else if (ex_ready_i) begin
      // EX consumed the old entry and nothing replaced it
      valid_q <= 1'b0;
    end
  end

  // Fields are only written when a unit will read them, saving toggles
  always_ff @(posedge clk) begin
    if (xfer) begin
      pc_q <= if_id_i.pc;
      if (dec_i.alu_en) begin
        alu_bch_q <= dec_i.alu_bch;
        alu_jmp_q <= dec_i.alu_jmp;
        alu_op_q  <= dec_i.alu_op;
      end
      // Operands feed both ALU and LSU
      if (dec_i.alu_en || dec_i.lsu_en) begin
        op_a_q <= operand_a_i;
        op_b_q <= operand_b_i;
        op_c_q <= operand_c_i;
      end
      if (dec_i.lsu_en) begin
        lsu_we_q   <= dec_i.lsu_we;
        lsu_size_q <= dec_i.lsu_size;
        lsu_sext_q <= dec_i.lsu_sext;
      end
      if (dec_i.rf_we) begin
        rf_waddr_q <= dec_i.rf_waddr;
      end
      // EX needs the fall-through address only for not-taken branches
      if (dec_i.alu_en && dec_i.alu_bch) begin
        pc_next_q <= pc_next_i;
      end
    end
  end

  always_comb begin
    id_ex_o.instr_valid  = valid_q;
    id_ex_o.pc           = pc_q;
    id_ex_o.pc_next      = pc_next_q;
    id_ex_o.alu_en       = alu_en_q;
    id_ex_o.alu_bch      = alu_bch_q;
    id_ex_o.alu_jmp      = alu_jmp_q;
    id_ex_o.alu_op       = alu_op_q;
    id_ex_o.operand_a    = op_a_q;
    id_ex_o.operand_b    = op_b_q;
    id_ex_o.operand_c    = op_c_q;
    id_ex_o.lsu_en       = lsu_en_q;
    id_ex_o.lsu_we       = lsu_we_q;
    id_ex_o.lsu_size     = lsu_size_q;
    id_ex_o.lsu_sext     = lsu_sext_q;
    id_ex_o.rf_we        = rf_we_q;
    id_ex_o.rf_waddr     = rf_waddr_q;
    id_ex_o.illegal_insn = illegal_q;
  end

endmodule

// File: src/decode_stage.sv
// Register file sits outside and must return rf_rdata_i combinationally for rf_raddr_o
module decode_stage import id_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  if_id_t               if_id_i,
  input  ctrl_t                ctrl_i,
  input  byp_t                 byp_i,
  input  logic [1:0][XLEN-1:0] rf_rdata_i,
  input  logic [XLEN-1:0]      rf_wdata_ex_i,
  input  logic [XLEN-1:0]      rf_wdata_wb_i,
  input  logic                 ex_ready_i,
  output rf_addr_t [1:0]       rf_raddr_o,
  output logic [XLEN-1:0]      jmp_target_o,
  output logic                 id_valid_o,
  output logic                 id_ready_o,
  output id_ex_t               id_ex_o
);

  dec_ctrl_t       dec;
  imm_set_t        imm;
  logic [XLEN-1:0] rs1_fw;
  logic [XLEN-1:0] bch_target;
  logic [XLEN-1:0] pc_next;
  logic [XLEN-1:0] operand_a;
  logic [XLEN-1:0] operand_b;
  logic [XLEN-1:0] operand_c;

  // Read both sources speculatively, even for formats without rs2
  assign rf_raddr_o[0] = if_id_i.instr.r.rs1;
  assign rf_raddr_o[1] = if_id_i.instr.r.rs2;

  //////////////////////////////////////////////////////////////////////
  // Decode and immediates
  //////////////////////////////////////////////////////////////////////

  instr_decoder u_decoder (
    .instr_i (if_id_i.instr),
    .dec_o   (dec)
  );

  imm_gen u_imm_gen (
    .instr_i (if_id_i.instr),
    .imm_o   (imm)
  );

  //////////////////////////////////////////////////////////////////////
  // Operands and targets
  //////////////////////////////////////////////////////////////////////

  operand_mux u_operand_mux (
    .dec_i         (dec),
    .imm_i         (imm),
    .pc_i          (if_id_i.pc),
    .byp_i         (byp_i),
    .rf_rdata_i    (rf_rdata_i),
    .rf_wdata_ex_i (rf_wdata_ex_i),
    .rf_wdata_wb_i (rf_wdata_wb_i),
    .bch_target_i  (bch_target),
    .rs1_fw_o      (rs1_fw),
    .operand_a_o   (operand_a),
    .operand_b_o   (operand_b),
    .operand_c_o   (operand_c)
  );

  // Jump target goes straight to IF, same cycle
  pc_target u_pc_target (
    .dec_i        (dec),
    .imm_i        (imm),
    .pc_i         (if_id_i.pc),
    .rs1_fw_i     (rs1_fw),
    .bch_target_o (bch_target),
    .jmp_target_o (jmp_target_o),
    .pc_next_o    (pc_next)
  );

  // ID/EX register and handshake
  id_ex_pipe u_id_ex_pipe (
    .clk         (clk),
    .rst_n       (rst_n),
    .if_id_i     (if_id_i),
    .ctrl_i      (ctrl_i),
    .ex_ready_i  (ex_ready_i),
    .dec_i       (dec),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .operand_c_i (operand_c),
    .pc_next_i   (pc_next),
    .id_valid_o  (id_valid_o),
    .id_ready_o  (id_ready_o),
    .id_ex_o     (id_ex_o)
  );

endmodule

// File: testbench/decode_checker.sv
// Expects at most one queued record per cycle, kill and halt held low; payload compared where captured
module decode_checker import id_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 instr_valid_i,
  input  logic                 id_valid_i,
  input  logic                 id_ready_i,
  input  logic                 ex_ready_i,
  input  rf_addr_t [1:0]       rf_raddr_i,
  input  logic [XLEN-1:0]      jmp_target_i,
  input  id_ex_t               id_ex_i,
  input  logic [12:0][31:0]    exp_i,
  output int unsigned          tests_done_o,
  output int unsigned          err_cnt_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // Records waiting for their ID/EX cycle, with the result of the transfer-time checks
  logic [12:0][31:0] exp_q[$];
  int                num_q[$];
  bit                jbad_q[$];

  int unsigned pushed = 0;
  int unsigned done_cnt = 0;
  int unsigned err_cnt = 0;
  int unsigned pass_cnt = 0;
  int unsigned cycle = 0;
  logic        model_valid = 1'b0;
  logic        prev_ready = 1'b1;
  id_ex_t      prev_ex = '0;

  assign tests_done_o = done_cnt;
  assign err_cnt_o    = err_cnt;

  // One field compare, with a fail line on mismatch
  task automatic check_field(input int num, input string field, input logic [31:0] exp,
                             input logic [31:0] act, inout bit bad);
    if (exp !== act) begin
      $display("[FAIL] vec%0d %s expected %h actual %h", num, field, exp, act);
      err_cnt++;
      bad = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare one captured instruction
  //////////////////////////////////////////////////////////////////////

  task automatic compare_record(input logic [12:0][31:0] rec, input int num, input bit jbad);
    logic [31:0] flags;
    logic [6:0]  opc;
    bit          bad;
    flags = rec[7];
    opc   = rec[0][6:0];
    bad   = jbad;
    // Flag word nibbles, alu_en lsu_en rf_we illegal alu_op lsu_we lsu_size lsu_sext
    check_field(num, "alu_en", 32'(flags[28]), 32'(id_ex_i.alu_en), bad);
    check_field(num, "lsu_en", 32'(flags[24]), 32'(id_ex_i.lsu_en), bad);
    check_field(num, "rf_we", 32'(flags[20]), 32'(id_ex_i.rf_we), bad);
    check_field(num, "illegal_insn", 32'(flags[16]), 32'(id_ex_i.illegal_insn), bad);
    check_field(num, "pc", rec[1], id_ex_i.pc, bad);
    if (flags[28]) begin
      check_field(num, "alu_op", 32'(flags[15:12]), 32'(id_ex_i.alu_op), bad);
      check_field(num, "alu_bch", 32'(opc == OPC_BRANCH), 32'(id_ex_i.alu_bch), bad);
      check_field(num, "alu_jmp", 32'(opc == OPC_JAL || opc == OPC_JALR),
                  32'(id_ex_i.alu_jmp), bad);
    end
    // Fall-through address only travels with branches
    if (flags[28] && opc == OPC_BRANCH) begin
      check_field(num, "pc_next", rec[1] + 32'd4, id_ex_i.pc_next, bad);
    end
    if (flags[28] || flags[24]) begin
      check_field(num, "operand_a", rec[8], id_ex_i.operand_a, bad);
      check_field(num, "operand_b", rec[9], id_ex_i.operand_b, bad);
      check_field(num, "operand_c", rec[10], id_ex_i.operand_c, bad);
    end
    if (flags[24]) begin
      check_field(num, "lsu_we", 32'(flags[8]), 32'(id_ex_i.lsu_we), bad);
      check_field(num, "lsu_size", 32'(flags[5:4]), 32'(id_ex_i.lsu_size), bad);
      check_field(num, "lsu_sext", 32'(flags[0]), 32'(id_ex_i.lsu_sext), bad);
    end
    if (flags[20]) begin
      check_field(num, "rf_waddr", 32'(rec[11][4:0]), 32'(id_ex_i.rf_waddr), bad);
    end
    if (bad) begin
      $display("vec%0d finished with mismatches", num);
    end else begin
      $display("[PASS] vec%0d", num);
      pass_cnt++;
    end
    done_cnt++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Handshake watcher
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    logic [12:0][31:0] rec;
    bit                jbad;
    int                num;
    cycle++;
    if (!rst_n) begin
      model_valid = 1'b0;
      prev_ready  = 1'b1;
    end else begin
      // No kill or halt, so ID is valid with IF and ready with EX
      if (id_valid_i !== instr_valid_i) begin
        $display("[FAIL] handshake id_valid_o expected %b actual %b in cycle %0d",
                 instr_valid_i, id_valid_i, cycle);
        err_cnt++;
      end
      if (id_ready_i !== ex_ready_i) begin
        $display("[FAIL] handshake id_ready_o expected %b actual %b in cycle %0d",
                 ex_ready_i, id_ready_i, cycle);
        err_cnt++;
      end
      // Valid follows transfers, clears once EX drains, holds under stall
      if (id_ex_i.instr_valid !== model_valid) begin
        $display("[FAIL] handshake instr_valid expected %b actual %b in cycle %0d",
                 model_valid, id_ex_i.instr_valid, cycle);
        err_cnt++;
      end
      if (!prev_ready && id_ex_i !== prev_ex) begin
        $display("ID/EX output changed while EX was stalled in cycle %0d", cycle);
        err_cnt++;
      end
      // Instruction captured on the previous edge
      if (exp_q.size() > 0) begin
        rec  = exp_q.pop_front();
        num  = num_q.pop_front();
        jbad = jbad_q.pop_front();
        compare_record(rec, num, jbad);
      end
      if (id_valid_i && ex_ready_i) begin
        jbad = 1'b0;
        // Read addresses are the rs1 and rs2 fields of the instruction
        check_field(int'(pushed), "rf_raddr0", 32'(exp_i[0][19:15]),
                    32'(rf_raddr_i[0]), jbad);
        check_field(int'(pushed), "rf_raddr1", 32'(exp_i[0][24:20]),
                    32'(rf_raddr_i[1]), jbad);
        // Jump target is combinational, checked at the transfer itself
        if (exp_i[11][8]) begin
          check_field(int'(pushed), "jmp_target", exp_i[12], jmp_target_i, jbad);
        end
        exp_q.push_back(exp_i);
        num_q.push_back(int'(pushed));
        jbad_q.push_back(jbad);
        pushed++;
        model_valid = 1'b1;
      end else if (ex_ready_i) begin
        model_valid = 1'b0;
      end
      prev_ready = ex_ready_i;
      prev_ex    = id_ex_i;
    end
  end

  task automatic print_summary();
    $display("Tests %0d, passed %0d, errors %0d", done_cnt, pass_cnt, err_cnt);
  endtask

endmodule

// File: testbench/tb_decode_stage.sv
// Vectors come from testbench/decode_vectors.hex, 13 words each; run from the project root
module tb_decode_stage import id_pkg::*;;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_VEC   = 19;
  localparam int REC_WORDS = 13;
  localparam int LIMIT     = NUM_VEC * 8 + 20;

  logic                 clk = 1'b0;
  logic                 rst_n = 1'b0;
  if_id_t               if_id = '0;
  ctrl_t                ctrl = '0;
  byp_t                 byp = '0;
  logic [1:0][XLEN-1:0] rf_rdata = '0;
  logic [XLEN-1:0]      wdata_ex = '0;
  logic [XLEN-1:0]      wdata_wb = '0;
  logic                 ex_ready = 1'b1;
  rf_addr_t [1:0]       rf_raddr;
  logic [XLEN-1:0]      jmp_target;
  logic                 id_valid;
  logic                 id_ready;
  id_ex_t               id_ex;

  logic [31:0]       vec_mem [0:NUM_VEC*REC_WORDS-1];
  logic [12:0][31:0] cur_exp = '0;
  int                vec_idx = 0;
  int                rst_cnt = 0;
  int                cycle = 0;
  int unsigned       tests_done;
  int unsigned       err_cnt;

  always #5 clk = ~clk;

  decode_stage UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .if_id_i       (if_id),
    .ctrl_i        (ctrl),
    .byp_i         (byp),
    .rf_rdata_i    (rf_rdata),
    .rf_wdata_ex_i (wdata_ex),
    .rf_wdata_wb_i (wdata_wb),
    .ex_ready_i    (ex_ready),
    .rf_raddr_o    (rf_raddr),
    .jmp_target_o  (jmp_target),
    .id_valid_o    (id_valid),
    .id_ready_o    (id_ready),
    .id_ex_o       (id_ex)
  );

  decode_checker u_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (if_id.instr_valid),
    .id_valid_i    (id_valid),
    .id_ready_i    (id_ready),
    .ex_ready_i    (ex_ready),
    .rf_raddr_i    (rf_raddr),
    .jmp_target_i  (jmp_target),
    .id_ex_i       (id_ex),
    .exp_i         (cur_exp),
    .tests_done_o  (tests_done),
    .err_cnt_o     (err_cnt)
  );

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Word order: instr pc rdata0 rdata1 ex wb sel flags op_a op_b op_c waddr jmp
  task automatic apply_vector(input int n);
    logic [12:0][31:0] rec;
    if (n >= NUM_VEC) begin
      if_id.instr_valid <= 1'b0;
    end else begin
      for (int k = 0; k < REC_WORDS; k++) begin
        rec[k] = vec_mem[n*REC_WORDS+k];
      end
      if_id.instr_valid <= 1'b1;
      if_id.instr       <= rec[0];
      if_id.pc          <= rec[1];
      rf_rdata[0]       <= rec[2];
      rf_rdata[1]       <= rec[3];
      wdata_ex          <= rec[4];
      wdata_wb          <= rec[5];
      byp.fw_a_sel      <= fw_sel_e'(rec[6][5:4]);
      byp.fw_b_sel      <= fw_sel_e'(rec[6][1:0]);
      cur_exp           <= rec;
    end
  endtask

  // Vector held until its transfer, EX stalls about one cycle in four
  always @(posedge clk) begin
    if (rst_cnt < 5) begin
      rst_cnt <= rst_cnt + 1;
      if (rst_cnt == 4) begin
        rst_n <= 1'b1;
        apply_vector(0);
      end
    end else begin
      if (id_valid && ex_ready) begin
        vec_idx <= vec_idx + 1;
        apply_vector(vec_idx + 1);
      end
      ex_ready <= ($urandom % 4) != 0;
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= LIMIT) begin
      $display("Timeout after %0d cycles with %0d of %0d vectors checked",
               cycle, tests_done, NUM_VEC);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'heab7_05df));
    $readmemh("testbench/decode_vectors.hex", vec_mem);
    wait (tests_done == NUM_VEC);
    repeat (3) @(posedge clk);
    u_checker.print_summary();
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: testbench/decode_vectors.hex
// instr pc rdata0 rdata1 fw_ex fw_wb sel(a,b) flags op_a op_b op_c waddr(bit8 jmp check) jmp
// flags nibbles: alu_en lsu_en rf_we illegal alu_op lsu_we lsu_size lsu_sext
002081b3 00000100 00001000 00000050 aaaa0000 0bbb0000 00000000 10100000 00001000 00000050 00000050 00000003 00000000
402082b3 00000104 00001000 00000050 aaaa0000 0bbb0000 00000000 10101000 00001000 00000050 00000050 00000005 00000000
00208033 00000108 00001000 00000050 aaaa0000 0bbb0000 00000000 10000000 00001000 00000050 00000050 00000000 00000000
ffb08313 0000010c 00001000 00000050 aaaa0000 0bbb0000 00000000 10100000 00001000 fffffffb 00000050 00000006 00000000
4030d393 00000110 00001000 00000050 aaaa0000 0bbb0000 00000000 10107000 00001000 00000403 00000050 00000007 00000000
002081b3 00000114 00001000 00000050 aaaa0000 0bbb0000 00000012 10100000 aaaa0000 0bbb0000 0bbb0000 00000003 00000000
00c0a403 00000118 00001000 00000050 aaaa0000 0bbb0000 00000000 01100021 00001000 0000000c 00000050 00000008 00000000
fff0c483 0000011c 00001000 00000050 aaaa0000 0bbb0000 00000000 01100000 00001000 ffffffff 00000050 00000009 00000000
0020a423 00000120 00001000 00000050 aaaa0000 0bbb0000 00000000 01000120 00001000 00000008 00000050 00000000 00000000
fe209e23 00000124 00001000 00000050 aaaa0000 0bbb0000 00000001 01000110 00001000 fffffffc aaaa0000 00000000 00000000
00208863 00000200 00001000 00000050 aaaa0000 0bbb0000 00000000 1000a000 00001000 00000050 00000210 00000000 00000000
fe20dce3 00000200 00001000 00000050 aaaa0000 0bbb0000 00000000 1000d000 00001000 00000050 000001f8 00000000 00000000
001000ef 00000300 00001000 00000050 aaaa0000 0bbb0000 00000000 10100000 00000300 00000004 00000050 00000101 00000b00
007082e7 00000300 00001000 00000050 aaaa0000 0bbb0000 00000020 10100000 00000300 00000004 00000050 00000105 0bbb0006
12345537 00000400 00001000 00000050 aaaa0000 0bbb0000 00000000 10100000 00000000 12345000 00000050 0000000a 00000000
fffff597 00000400 00001000 00000050 aaaa0000 0bbb0000 00000000 10100000 00000400 fffff000 00000050 0000000b 00000000
0000007f 00000500 00001000 00000050 aaaa0000 0bbb0000 00000000 00010000 00000000 00000000 00000000 00000000 00000000
022081b3 00000504 00001000 00000050 aaaa0000 0bbb0000 00000000 00010000 00000000 00000000 00000000 00000000 00000000
0020a063 00000508 00001000 00000050 aaaa0000 0bbb0000 00000000 00010000 00000000 00000000 00000000 00000000 00000000

// File: flist.f
src/id_pkg.sv
src/imm_gen.sv
src/instr_decoder.sv
src/operand_mux.sv
src/pc_target.sv
src/id_ex_pipe.sv
src/decode_stage.sv
testbench/decode_checker.sv
testbench/tb_decode_stage.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= tb_decode_stage
FLIST     ?= flist.f

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) -o V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test passed"

clean:
	rm -rf obj_dir
